// ==== mem2x_pkg.sv ====
// #########################################################
// double-pumped memory shared types
// #########################################################
`default_nettype none

package mem2x_pkg;

  // word geometry of the shared RAM
  localparam int DATA_BITS = 32;
  localparam int BYTE_COUNT = DATA_BITS / 8;

  // address width covers the largest supported depth of 256 words
  localparam int ADDR_BITS = 8;

  // clk cycles from a sampled read strobe to its readdatavalid
  localparam int READ_LATENCY = 4;

  // one memory word
  typedef logic [DATA_BITS-1:0] data_t;

  // one write enable per byte lane of data_t
  typedef logic [BYTE_COUNT-1:0] byte_en_t;

  // word address, only the low bits reach a smaller RAM
  typedef logic [ADDR_BITS-1:0] addr_t;

  // clk2x slot inside one clk cycle
  // ports 1 and 3 own the first slot, ports 2 and 4 the second
  typedef enum logic {
    SLOT_FIRST  = 1'b0,
    SLOT_SECOND = 1'b1
  } slot_e;

endpackage

`default_nettype wire

// ==== mem2x_port_capture.sv ====
// #########################################################
// port capture and slot multiplexer
// #########################################################
`timescale 1ns/1ps
`default_nettype none

module mem2x_port_capture (
  input  logic                clk,
  input  logic                clk2x,
  input  logic                resetn,
  input  mem2x_pkg::addr_t    port1_address,
  input  mem2x_pkg::addr_t    port2_address,
  input  mem2x_pkg::addr_t    port3_address,
  input  mem2x_pkg::addr_t    port4_address,
  input  logic                port1_write,
  input  logic                port2_write,
  input  logic                port3_write,
  input  logic                port4_write,
  input  mem2x_pkg::data_t    port1_writedata,
  input  mem2x_pkg::data_t    port2_writedata,
  input  mem2x_pkg::data_t    port3_writedata,
  input  mem2x_pkg::data_t    port4_writedata,
  input  mem2x_pkg::byte_en_t port1_byteenable,
  input  mem2x_pkg::byte_en_t port2_byteenable,
  input  mem2x_pkg::byte_en_t port3_byteenable,
  input  mem2x_pkg::byte_en_t port4_byteenable,
  output mem2x_pkg::addr_t    slot_a_address,
  output mem2x_pkg::addr_t    slot_b_address,
  output logic                slot_a_write,
  output logic                slot_b_write,
  output mem2x_pkg::data_t    slot_a_writedata,
  output mem2x_pkg::data_t    slot_b_writedata,
  output mem2x_pkg::byte_en_t slot_a_byteenable,
  output mem2x_pkg::byte_en_t slot_b_byteenable
);

  mem2x_pkg::addr_t    addr1_q, addr2_q, addr3_q, addr4_q;
  mem2x_pkg::data_t    data1_q, data2_q, data3_q, data4_q;
  mem2x_pkg::byte_en_t be1_q, be2_q, be3_q, be4_q;
  logic                write1_q, write2_q, write3_q, write4_q;

  logic                clk_toggle;
  logic                toggle_2x;
  logic                toggle_2x_dly;
  mem2x_pkg::slot_e    slot;

  // the write strobes and the phase toggle must be known out of reset
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      clk_toggle <= 1'b0;
      write1_q   <= 1'b0;
      write2_q   <= 1'b0;
      write3_q   <= 1'b0;
      write4_q   <= 1'b0;
    end else begin
      clk_toggle <= ~clk_toggle;
      write1_q   <= port1_write;
      write2_q   <= port2_write;
      write3_q   <= port3_write;
      write4_q   <= port4_write;
    end
  end

  always_ff @(posedge clk) begin
    addr1_q <= port1_address;
    addr2_q <= port2_address;
    addr3_q <= port3_address;
    addr4_q <= port4_address;
    data1_q <= port1_writedata;
    data2_q <= port2_writedata;
    data3_q <= port3_writedata;
    data4_q <= port4_writedata;
    be1_q   <= port1_byteenable;
    be2_q   <= port2_byteenable;
    be3_q   <= port3_byteenable;
    be4_q   <= port4_byteenable;
  end

  // two clk2x samples of the toggle agree only on the mid-cycle edge
  always_ff @(posedge clk2x or negedge resetn) begin
    if (!resetn) begin
      toggle_2x     <= 1'b0;
      toggle_2x_dly <= 1'b0;
    end else begin
      toggle_2x     <= clk_toggle;
      toggle_2x_dly <= toggle_2x;
    end
  end

  always_comb begin
    if (toggle_2x == toggle_2x_dly) begin
      slot = mem2x_pkg::SLOT_FIRST;
    end else begin
      slot = mem2x_pkg::SLOT_SECOND;
    end
  end

  // physical port a carries ports 1 and 2, port b carries ports 3 and 4
  always_ff @(posedge clk2x or negedge resetn) begin
    if (!resetn) begin
      slot_a_write <= 1'b0;
      slot_b_write <= 1'b0;
    end else if (slot == mem2x_pkg::SLOT_FIRST) begin
      slot_a_write <= write1_q;
      slot_b_write <= write3_q;
    end else begin
      slot_a_write <= write2_q;
      slot_b_write <= write4_q;
    end
  end

  always_ff @(posedge clk2x) begin
    if (slot == mem2x_pkg::SLOT_FIRST) begin
      slot_a_address    <= addr1_q;
      slot_b_address    <= addr3_q;
      slot_a_writedata  <= data1_q;
      slot_b_writedata  <= data3_q;
      slot_a_byteenable <= be1_q;
      slot_b_byteenable <= be3_q;
    end else begin
      slot_a_address    <= addr2_q;
      slot_b_address    <= addr4_q;
      slot_a_writedata  <= data2_q;
      slot_b_writedata  <= data4_q;
      slot_a_byteenable <= be2_q;
      slot_b_byteenable <= be4_q;
    end
  end

endmodule

`default_nettype wire

// ==== mem2x_bram.sv ====
// #########################################################
// byte-enabled true dual-port RAM
// #########################################################
`timescale 1ns/1ps
`default_nettype none

module mem2x_bram #(
  parameter int DEPTH_WORDS = 256
) (
  input  logic                clk2x,
  input  mem2x_pkg::addr_t    addr_a,
  input  mem2x_pkg::addr_t    addr_b,
  input  logic                we_a,
  input  logic                we_b,
  input  mem2x_pkg::data_t    wdata_a,
  input  mem2x_pkg::data_t    wdata_b,
  input  mem2x_pkg::byte_en_t be_a,
  input  mem2x_pkg::byte_en_t be_b,
  output mem2x_pkg::data_t    q_a,
  output mem2x_pkg::data_t    q_b
);

  // index width of the storage, the upper address bits are ignored
  localparam int IDX_BITS = $clog2(DEPTH_WORDS);

  mem2x_pkg::data_t    mem [DEPTH_WORDS];
  logic [IDX_BITS-1:0] rd_idx_a;
  logic [IDX_BITS-1:0] rd_idx_b;

  // writes land at the request edge, the read address is held one edge
  // and the word is registered on the next, so data trails by two edges
  always_ff @(posedge clk2x) begin
    for (int i = 0; i < mem2x_pkg::BYTE_COUNT; i++) begin
      if (we_a && be_a[i]) begin
        mem[addr_a[IDX_BITS-1:0]][i*8 +: 8] <= wdata_a[i*8 +: 8];
      end
      if (we_b && be_b[i]) begin
        mem[addr_b[IDX_BITS-1:0]][i*8 +: 8] <= wdata_b[i*8 +: 8];
      end
    end
    rd_idx_a <= addr_a[IDX_BITS-1:0];
    rd_idx_b <= addr_b[IDX_BITS-1:0];
    q_a      <= mem[rd_idx_a];
    q_b      <= mem[rd_idx_b];
  end

endmodule

`default_nettype wire

// ==== mem2x_read_return.sv ====
// #########################################################
// read data return to the clk ports
// #########################################################
`timescale 1ns/1ps
`default_nettype none

module mem2x_read_return (
  input  logic             clk,
  input  logic             clk2x,
  input  logic             resetn,
  input  mem2x_pkg::data_t q_a,
  input  mem2x_pkg::data_t q_b,
  input  logic             port1_read,
  input  logic             port2_read,
  input  logic             port3_read,
  input  logic             port4_read,
  output mem2x_pkg::data_t port1_readdata,
  output mem2x_pkg::data_t port2_readdata,
  output mem2x_pkg::data_t port3_readdata,
  output mem2x_pkg::data_t port4_readdata,
  output logic             port1_readdatavalid,
  output logic             port2_readdatavalid,
  output logic             port3_readdatavalid,
  output logic             port4_readdatavalid
);

  localparam int NUM_PORTS = 4;
  localparam int LAT = mem2x_pkg::READ_LATENCY;

  // d1 is one clk2x edge behind the RAM output, d2 is two edges behind
  mem2x_pkg::data_t q_a_d1, q_a_d2;
  mem2x_pkg::data_t q_b_d1, q_b_d2;

  logic [NUM_PORTS-1:0]          read_vec;
  logic [NUM_PORTS-1:0][LAT-1:0] valid_pipe;

  always_ff @(posedge clk2x) begin
    q_a_d1 <= q_a;
    q_a_d2 <= q_a_d1;
    q_b_d1 <= q_b;
    q_b_d2 <= q_b_d1;
  end

  // first slot words left the RAM one clk2x edge earlier than second slot
  // words, so at the clk edge they sit in the older stage
  always_ff @(posedge clk) begin
    port1_readdata <= q_a_d2;
    port2_readdata <= q_a_d1;
    port3_readdata <= q_b_d2;
    port4_readdata <= q_b_d1;
  end

  assign read_vec = {port4_read, port3_read, port2_read, port1_read};

  // one shift register per port, several reads may be in flight at once
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      valid_pipe <= '0;
    end else begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        valid_pipe[p] <= {valid_pipe[p][LAT-2:0], read_vec[p]};
      end
    end
  end

  assign port1_readdatavalid = valid_pipe[0][LAT-1];
  assign port2_readdatavalid = valid_pipe[1][LAT-1];
  assign port3_readdatavalid = valid_pipe[2][LAT-1];
  assign port4_readdatavalid = valid_pipe[3][LAT-1];

endmodule

`default_nettype wire

// ==== mem2x_top.sv ====
// #########################################################
// double-pumped four-port memory
// #########################################################
`timescale 1ns/1ps
`default_nettype none

module mem2x_top #(
  parameter int DEPTH_WORDS = 256
) (
  input  logic                clk,
  input  logic                clk2x,
  input  logic                resetn,
  input  mem2x_pkg::addr_t    port1_address,
  input  logic                port1_read,
  input  logic                port1_write,
  input  mem2x_pkg::data_t    port1_writedata,
  input  mem2x_pkg::byte_en_t port1_byteenable,
  output mem2x_pkg::data_t    port1_readdata,
  output logic                port1_readdatavalid,
  input  mem2x_pkg::addr_t    port2_address,
  input  logic                port2_read,
  input  logic                port2_write,
  input  mem2x_pkg::data_t    port2_writedata,
  input  mem2x_pkg::byte_en_t port2_byteenable,
  output mem2x_pkg::data_t    port2_readdata,
  output logic                port2_readdatavalid,
  input  mem2x_pkg::addr_t    port3_address,
  input  logic                port3_read,
  input  logic                port3_write,
  input  mem2x_pkg::data_t    port3_writedata,
  input  mem2x_pkg::byte_en_t port3_byteenable,
  output mem2x_pkg::data_t    port3_readdata,
  output logic                port3_readdatavalid,
  input  mem2x_pkg::addr_t    port4_address,
  input  logic                port4_read,
  input  logic                port4_write,
  input  mem2x_pkg::data_t    port4_writedata,
  input  mem2x_pkg::byte_en_t port4_byteenable,
  output mem2x_pkg::data_t    port4_readdata,
  output logic                port4_readdatavalid
);

  // slot requests towards the RAM
  mem2x_pkg::addr_t    slot_a_address;
  mem2x_pkg::addr_t    slot_b_address;
  logic                slot_a_write;
  logic                slot_b_write;
  mem2x_pkg::data_t    slot_a_writedata;
  mem2x_pkg::data_t    slot_b_writedata;
  mem2x_pkg::byte_en_t slot_a_byteenable;
  mem2x_pkg::byte_en_t slot_b_byteenable;

  // RAM result streams, one word per clk2x slot
  mem2x_pkg::data_t    q_a;
  mem2x_pkg::data_t    q_b;

  mem2x_port_capture mem2x_port_capture_i (
    .clk               (clk),
    .clk2x             (clk2x),
    .resetn            (resetn),
    .port1_address     (port1_address),
    .port2_address     (port2_address),
    .port3_address     (port3_address),
    .port4_address     (port4_address),
    .port1_write       (port1_write),
    .port2_write       (port2_write),
    .port3_write       (port3_write),
    .port4_write       (port4_write),
    .port1_writedata   (port1_writedata),
    .port2_writedata   (port2_writedata),
    .port3_writedata   (port3_writedata),
    .port4_writedata   (port4_writedata),
    .port1_byteenable  (port1_byteenable),
    .port2_byteenable  (port2_byteenable),
    .port3_byteenable  (port3_byteenable),
    .port4_byteenable  (port4_byteenable),
    .slot_a_address    (slot_a_address),
    .slot_b_address    (slot_b_address),
    .slot_a_write      (slot_a_write),
    .slot_b_write      (slot_b_write),
    .slot_a_writedata  (slot_a_writedata),
    .slot_b_writedata  (slot_b_writedata),
    .slot_a_byteenable (slot_a_byteenable),
    .slot_b_byteenable (slot_b_byteenable)
  );

  mem2x_bram #(
    .DEPTH_WORDS (DEPTH_WORDS)
  ) mem2x_bram_i (
    .clk2x   (clk2x),
    .addr_a  (slot_a_address),
    .addr_b  (slot_b_address),
    .we_a    (slot_a_write),
    .we_b    (slot_b_write),
    .wdata_a (slot_a_writedata),
    .wdata_b (slot_b_writedata),
    .be_a    (slot_a_byteenable),
    .be_b    (slot_b_byteenable),
    .q_a     (q_a),
    .q_b     (q_b)
  );

  mem2x_read_return mem2x_read_return_i (
    .clk                 (clk),
    .clk2x               (clk2x),
    .resetn              (resetn),
    .q_a                 (q_a),
    .q_b                 (q_b),
    .port1_read          (port1_read),
    .port2_read          (port2_read),
    .port3_read          (port3_read),
    .port4_read          (port4_read),
    .port1_readdata      (port1_readdata),
    .port2_readdata      (port2_readdata),
    .port3_readdata      (port3_readdata),
    .port4_readdata      (port4_readdata),
    .port1_readdatavalid (port1_readdatavalid),
    .port2_readdatavalid (port2_readdatavalid),
    .port3_readdatavalid (port3_readdatavalid),
    .port4_readdatavalid (port4_readdatavalid)
  );

endmodule

`default_nettype wire

// ==== tb_mem2x_assert.sv ====
// ##########################################################
// readdatavalid timing checks
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

module tb_mem2x_assert (
  input logic clk,
  input logic resetn,
  input logic port1_read,
  input logic port2_read,
  input logic port3_read,
  input logic port4_read,
  input logic port1_readdatavalid,
  input logic port2_readdatavalid,
  input logic port3_readdatavalid,
  input logic port4_readdatavalid
);

  localparam int LAT = mem2x_pkg::READ_LATENCY;

  logic [3:0] rd_vec;
  logic [3:0] vld_vec;
  int         fail_count = 0;

  assign rd_vec  = {port4_read, port3_read, port2_read, port1_read};
  assign vld_vec = {port4_readdatavalid, port3_readdatavalid,
                    port2_readdatavalid, port1_readdatavalid};

  for (genvar p = 0; p < 4; p++) begin : port_checks
    latency_check: assert property (@(posedge clk) disable iff (!resetn)
        rd_vec[p] |-> ##LAT vld_vec[p])
      else begin
        fail_count++;
        $error("port %0d readdatavalid missing after read", p + 1);
      end

    reset_check: assert property (@(posedge clk) !resetn |-> !vld_vec[p])
      else begin
        fail_count++;
        $error("port %0d readdatavalid high in reset", p + 1);
      end

    // back-to-back valids need back-to-back reads
    pair_check: assert property (@(posedge clk) disable iff (!resetn)
        (vld_vec[p] && $past(vld_vec[p])) |-> ($past(rd_vec[p], LAT) && $past(rd_vec[p], LAT + 1)))
      else begin
        fail_count++;
        $error("port %0d readdatavalid held without reads", p + 1);
      end
  end

endmodule

bind mem2x_top tb_mem2x_assert tb_mem2x_assert_i (
  .clk                 (clk),
  .resetn              (resetn),
  .port1_read          (port1_read),
  .port2_read          (port2_read),
  .port3_read          (port3_read),
  .port4_read          (port4_read),
  .port1_readdatavalid (port1_readdatavalid),
  .port2_readdatavalid (port2_readdatavalid),
  .port3_readdatavalid (port3_readdatavalid),
  .port4_readdatavalid (port4_readdatavalid)
);

`default_nettype wire

// ==== tb_mem2x.sv ====
// ##########################################################
// double-pumped memory testbench
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

module tb_mem2x;

  localparam int CLK_PERIOD_NS = 4;
  localparam int RESET_CYCLES = 16;
  localparam int MODEL_WORDS = 256;
  localparam int FILL_CYCLES = 64;
  localparam int NUM_RANDOM_OPS = 400;
  localparam int DRAIN_TIMEOUT = 50;

  logic clk = 1'b0;
  // clk2x starts high so that its rising edges land on those of clk
  logic clk2x = 1'b1;
  logic resetn;

  // requests on the DUT pins, and the ones staged for the next cycle
  mem2x_pkg::addr_t    drv_addr [4];
  logic                drv_rd [4];
  logic                drv_wr [4];
  mem2x_pkg::data_t    drv_wd [4];
  mem2x_pkg::byte_en_t drv_be [4];
  mem2x_pkg::addr_t    nxt_addr [4];
  logic                nxt_rd [4];
  logic                nxt_wr [4];
  mem2x_pkg::data_t    nxt_wd [4];
  mem2x_pkg::byte_en_t nxt_be [4];

  mem2x_pkg::data_t    rdata [4];
  logic                rvalid [4];

  // expected reads in order of their due cycle
  int                  exp_port [$];
  int                  exp_due [$];
  mem2x_pkg::data_t    exp_data [$];

  mem2x_pkg::data_t    model_mem [MODEL_WORDS];
  int                  cycle;
  int                  data_errors;
  int                  valid_errors;
  int                  timeout_errors;
  int                  assert_errors;
  integer              seed;

  always #(CLK_PERIOD_NS / 2) clk = ~clk;
  always #(CLK_PERIOD_NS / 4) clk2x = ~clk2x;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  mem2x_top #(
    .DEPTH_WORDS (MODEL_WORDS)
  ) mem2x_top_i (
    .clk                 (clk),
    .clk2x               (clk2x),
    .resetn              (resetn),
    .port1_address       (drv_addr[0]),
    .port1_read          (drv_rd[0]),
    .port1_write         (drv_wr[0]),
    .port1_writedata     (drv_wd[0]),
    .port1_byteenable    (drv_be[0]),
    .port1_readdata      (rdata[0]),
    .port1_readdatavalid (rvalid[0]),
    .port2_address       (drv_addr[1]),
    .port2_read          (drv_rd[1]),
    .port2_write         (drv_wr[1]),
    .port2_writedata     (drv_wd[1]),
    .port2_byteenable    (drv_be[1]),
    .port2_readdata      (rdata[1]),
    .port2_readdatavalid (rvalid[1]),
    .port3_address       (drv_addr[2]),
    .port3_read          (drv_rd[2]),
    .port3_write         (drv_wr[2]),
    .port3_writedata     (drv_wd[2]),
    .port3_byteenable    (drv_be[2]),
    .port3_readdata      (rdata[2]),
    .port3_readdatavalid (rvalid[2]),
    .port4_address       (drv_addr[3]),
    .port4_read          (drv_rd[3]),
    .port4_write         (drv_wr[3]),
    .port4_writedata     (drv_wd[3]),
    .port4_byteenable    (drv_be[3]),
    .port4_readdata      (rdata[3]),
    .port4_readdatavalid (rvalid[3])
  );

  function automatic mem2x_pkg::data_t fill_word(input mem2x_pkg::addr_t a);
    return {a, ~a, a ^ 8'h5a, a + 8'h33};
  endfunction

  // one clk cycle in slot order, ports 1 and 3 first, then ports 2 and 4
  // returns the read word of port n in bits 32*(n-1) and up
  function automatic logic [127:0] model_cycle();
    logic [127:0] words;
    int           p;
    words = '0;
    for (int slot = 0; slot < 2; slot++) begin
      for (int k = 0; k < 2; k++) begin
        p = slot + 2 * k;
        if (drv_rd[p]) begin
          words[p*32 +: 32] = model_mem[drv_addr[p]];
        end
      end
      for (int k = 0; k < 2; k++) begin
        p = slot + 2 * k;
        for (int b = 0; b < 4; b++) begin
          if (drv_wr[p] && drv_be[p][b]) begin
            model_mem[drv_addr[p]][b*8 +: 8] = drv_wd[p][b*8 +: 8];
          end
        end
      end
    end
    return words;
  endfunction

  task automatic check_data(input string name, input mem2x_pkg::data_t expected,
                            input mem2x_pkg::data_t actual);
    if (actual !== expected) begin
      $display("ERROR %0t %s expected %h actual %h", $time, name, expected, actual);
      data_errors++;
    end
  endtask

  task automatic check_valid(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("ERROR %0t %s expected %b actual %b", $time, name, expected, actual);
      valid_errors++;
    end
  endtask

  task automatic set_req(input int p, input logic rd, input logic wr,
                         input mem2x_pkg::addr_t a, input mem2x_pkg::data_t d,
                         input mem2x_pkg::byte_en_t be);
    nxt_addr[p] = a;
    nxt_rd[p]   = rd;
    nxt_wr[p]   = wr;
    nxt_wd[p]   = d;
    nxt_be[p]   = be;
  endtask

  task automatic clear_reqs();
    for (int p = 0; p < 4; p++) begin
      set_req(p, 1'b0, 1'b0, '0, '0, '0);
    end
  endtask

  // drives the staged requests and queues the reads they return
  task automatic apply_cycle();
    logic [127:0] words;
    @(negedge clk);
    for (int p = 0; p < 4; p++) begin
      drv_addr[p] = nxt_addr[p];
      drv_rd[p]   = nxt_rd[p];
      drv_wr[p]   = nxt_wr[p];
      drv_wd[p]   = nxt_wd[p];
      drv_be[p]   = nxt_be[p];
    end
    words = model_cycle();
    for (int p = 0; p < 4; p++) begin
      if (drv_rd[p]) begin
        exp_port.push_back(p);
        exp_due.push_back(cycle + mem2x_pkg::READ_LATENCY);
        exp_data.push_back(words[p*32 +: 32]);
      end
    end
  endtask

  // a small address range makes cross-slot hazards frequent
  task automatic random_requests();
    int                  op;
    mem2x_pkg::addr_t    a;
    mem2x_pkg::data_t    d;
    mem2x_pkg::byte_en_t be;
    for (int p = 0; p < 4; p++) begin
      op = $random(seed) & 3;
      a  = mem2x_pkg::addr_t'($random(seed) & 15);
      d  = mem2x_pkg::data_t'($random(seed));
      be = mem2x_pkg::byte_en_t'($random(seed) & 15);
      set_req(p, op[0], op == 2, a, d, be);
    end
    // ports sharing a slot must not collide when one of them writes
    for (int s = 0; s < 2; s++) begin
      if (nxt_addr[s] == nxt_addr[s+2] && (nxt_wr[s] || nxt_wr[s+2])) begin
        nxt_addr[s+2] = nxt_addr[s] ^ 8'h01;
      end
    end
  endtask

  // outputs are stable at the falling edge
  always @(negedge clk) begin : compare
    logic             exp_v;
    mem2x_pkg::data_t exp_d;
    for (int p = 0; p < 4; p++) begin
      exp_v = 1'b0;
      exp_d = '0;
      for (int i = 0; i < exp_due.size(); i++) begin
        if (exp_due[i] == cycle && exp_port[i] == p) begin
          exp_v = 1'b1;
          exp_d = exp_data[i];
        end
      end
      check_valid($sformatf("port%0d_readdatavalid", p + 1), exp_v, rvalid[p]);
      if (exp_v) begin
        check_data($sformatf("port%0d_readdata", p + 1), exp_d, rdata[p]);
      end
    end
    while (exp_due.size() > 0 && exp_due[0] == cycle) begin
      void'(exp_port.pop_front());
      void'(exp_due.pop_front());
      void'(exp_data.pop_front());
    end
  end

  initial begin : main
    mem2x_pkg::addr_t a;
    int               wait_cycles;
    resetn         = 1'b1;
    seed           = 5869;
    data_errors    = 0;
    valid_errors   = 0;
    timeout_errors = 0;
    clear_reqs();
    for (int p = 0; p < 4; p++) begin
      drv_addr[p] = '0;
      drv_rd[p]   = 1'b0;
      drv_wr[p]   = 1'b0;
      drv_wd[p]   = '0;
      drv_be[p]   = '0;
    end
    // a clean falling edge puts every flop into reset
    #1;
    resetn = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    resetn = 1'b1;
    repeat (4) apply_cycle();

    // fill every word with full writes spread over all four ports
    for (int c = 0; c < FILL_CYCLES; c++) begin
      for (int p = 0; p < 4; p++) begin
        a = mem2x_pkg::addr_t'(4 * c + p);
        set_req(p, 1'b0, 1'b1, a, fill_word(a), 4'hf);
      end
      apply_cycle();
    end
    for (int c = 0; c < FILL_CYCLES; c++) begin
      for (int p = 0; p < 4; p++) begin
        a = mem2x_pkg::addr_t'(4 * c + (p + 1) % 4);
        set_req(p, 1'b1, 1'b0, a, '0, '0);
      end
      apply_cycle();
    end

    // partial byte enables merge into the fill word
    for (int p = 0; p < 4; p++) begin
      a = mem2x_pkg::addr_t'(8'h40 + p);
      set_req(p, 1'b0, 1'b1, a, 32'hc0de_0000 + p, mem2x_pkg::byte_en_t'(5 << p));
    end
    apply_cycle();
    for (int p = 0; p < 4; p++) begin
      set_req(p, 1'b1, 1'b0, mem2x_pkg::addr_t'(8'h40 + (p + 2) % 4), '0, '0);
    end
    apply_cycle();

    // first slot writes are seen by second slot reads of the same cycle
    set_req(0, 1'b0, 1'b1, 8'h50, 32'h1111_1111, 4'hf);
    set_req(1, 1'b1, 1'b0, 8'h50, '0, '0);
    set_req(2, 1'b0, 1'b1, 8'h51, 32'h3333_3333, 4'hf);
    set_req(3, 1'b1, 1'b0, 8'h51, '0, '0);
    apply_cycle();
    set_req(0, 1'b0, 1'b1, 8'h52, 32'h1414_1414, 4'hf);
    set_req(3, 1'b1, 1'b0, 8'h52, '0, '0);
    set_req(2, 1'b0, 1'b1, 8'h53, 32'h3232_3232, 4'hf);
    set_req(1, 1'b1, 1'b0, 8'h53, '0, '0);
    apply_cycle();
    // second slot writes come too late for first slot reads
    set_req(1, 1'b0, 1'b1, 8'h54, 32'h2121_2121, 4'hf);
    set_req(0, 1'b1, 1'b0, 8'h54, '0, '0);
    set_req(3, 1'b0, 1'b1, 8'h55, 32'h4343_4343, 4'hf);
    set_req(2, 1'b1, 1'b0, 8'h55, '0, '0);
    apply_cycle();

    repeat (NUM_RANDOM_OPS) begin
      random_requests();
      apply_cycle();
    end

    clear_reqs();
    apply_cycle();
    wait_cycles = 0;
    while (exp_due.size() > 0 && wait_cycles < DRAIN_TIMEOUT) begin
      @(posedge clk);
      wait_cycles++;
    end
    if (exp_due.size() > 0) begin
      $display("timeout: %0d expected reads never returned", exp_due.size());
      timeout_errors++;
    end
    repeat (4) apply_cycle();

    assert_errors = mem2x_top_i.tb_mem2x_assert_i.fail_count;
    $display("errors: data %0d, valid %0d, timeout %0d, assertion %0d",
             data_errors, valid_errors, timeout_errors, assert_errors);
    if (data_errors + valid_errors + timeout_errors + assert_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
mem2x_pkg.sv
mem2x_port_capture.sv
mem2x_bram.sv
mem2x_read_return.sv
mem2x_top.sv
tb_mem2x_assert.sv
tb_mem2x.sv

// ==== Bender.yml ====
package:
  name: mem2x

sources:
  - mem2x_pkg.sv
  - mem2x_port_capture.sv
  - mem2x_bram.sv
  - mem2x_read_return.sv
  - mem2x_top.sv
  - target: test
    files:
      - tb_mem2x_assert.sv
      - tb_mem2x.sv
